// File: files.f
+incdir+hdl
hdl/streamer_pkg.sv
hdl/stream_addr_gen.sv
hdl/stream_fifo.sv
hdl/load_source.sv
hdl/store_sink.sv
hdl/mem_arbiter.sv
hdl/streamer_top.sv
test/tb_clock_gen.sv
test/tb_streamer.sv

// File: Bender.yml
package:
  name: streamer

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/streamer_pkg.sv
      - hdl/stream_addr_gen.sv
      - hdl/stream_fifo.sv
      - hdl/load_source.sv
      - hdl/store_sink.sv
      - hdl/mem_arbiter.sv
      - hdl/streamer_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_clock_gen.sv
      - test/tb_streamer.sv

// File: test/tb_streamer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory model of 1024 words with random grant and random back-pressure.
// All test patterns stay below word address 1024.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "streamer_settings.svh"

module tb_streamer;

  import streamer_pkg::*;

  localparam logic [31:0] SEED      = 32'hdbe70e12;
  localparam int          MEM_WORDS = 1024;
  localparam logic [31:0] MEM_XOR   = 32'h5a3c_96e1;
  // Words moved over the whole run including the clear test
  localparam int TOTAL_WORDS    = 16 + 12 + 12 + 12 + 24 + 20 + 10;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_WORDS + 200;

  logic        clk;
  logic        rst_n;
  logic        clear;
  logic        x_start;
  logic        w_start;
  logic        z_start;
  chan_cfg_t   x_cfg, w_cfg, z_cfg;
  stream_t     x_stream, w_stream, z_stream;
  logic        x_ready, w_ready, z_ready;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  chan_flags_t x_flags, w_flags, z_flags;

  logic [`STREAMER_DATA_W-1:0] mem [MEM_WORDS];
  logic [`STREAMER_DATA_W-1:0] exp_mem [MEM_WORDS];
  logic [`STREAMER_DATA_W-1:0] x_exp [$];
  logic [`STREAMER_DATA_W-1:0] w_exp [$];
  logic [`STREAMER_DATA_W-1:0] z_words [$];
  int          x_idx, w_idx;
  int          x_done_cnt, w_done_cnt, z_done_cnt;
  int          checks, errors, cycles;
  string       test_name;

  function automatic logic [31:0] init_word(input int unsigned addr);
    return 32'(addr) ^ MEM_XOR;
  endfunction

  // Initial memory contents at base + k * stride
  function automatic logic [31:0] expected_word(input logic [15:0] base,
                                                input logic [15:0] stride, input int k);
    logic [15:0] addr;
    addr = base + 16'(k) * stride;
    return init_word(addr % MEM_WORDS);
  endfunction

  function automatic chan_cfg_t make_cfg(input int base, input int stride, input int count);
    chan_cfg_t cfg;
    cfg.base   = 16'(base);
    cfg.stride = 16'(stride);
    cfg.count  = 16'(count);
    return cfg;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s, %s: expected %0h, got %0h", test_name, what, exp, act);
    end
  endtask

  task automatic score_word(input string chan, input int idx, input int n,
                            input logic [31:0] exp, input logic [31:0] act);
    if (idx >= n) begin
      errors++;
      $display("Test %s: the %s stream delivered more words than its count", test_name, chan);
    end else begin
      compare_value($sformatf("%s word %0d", chan, idx), exp, act);
    end
  endtask

  tb_clock_gen clk_gen0 (
    .clk_o ( clk )
  );

  streamer_top dut0 (
    .clk_i      ( clk      ),
    .rst_n_i    ( rst_n    ),
    .clear_i    ( clear    ),
    .x_start_i  ( x_start  ),
    .w_start_i  ( w_start  ),
    .z_start_i  ( z_start  ),
    .x_cfg_i    ( x_cfg    ),
    .w_cfg_i    ( w_cfg    ),
    .z_cfg_i    ( z_cfg    ),
    .x_stream_o ( x_stream ),
    .w_stream_o ( w_stream ),
    .x_ready_i  ( x_ready  ),
    .w_ready_i  ( w_ready  ),
    .z_stream_i ( z_stream ),
    .z_ready_o  ( z_ready  ),
    .mem_req_o  ( mem_req  ),
    .mem_rsp_i  ( mem_rsp  ),
    .x_flags_o  ( x_flags  ),
    .w_flags_o  ( w_flags  ),
    .z_flags_o  ( z_flags  )
  );

  // Memory model with read data one cycle after the grant
  always @(posedge clk) begin
    mem_rsp.gnt    <= ($urandom_range(3) != 0);
    mem_rsp.rvalid <= 1'b0;
    if (mem_req.req && mem_rsp.gnt) begin
      if (mem_req.we) begin
        if (mem_req.addr >= MEM_WORDS) begin
          errors++;
          $display("Test %s: a write went beyond the memory model", test_name);
        end else begin
          mem[mem_req.addr] <= mem_req.wdata;
        end
      end else begin
        mem_rsp.rvalid <= 1'b1;
        mem_rsp.rdata  <= mem[mem_req.addr % MEM_WORDS];
      end
    end
  end

  // Random back-pressure on both load streams
  always @(posedge clk) begin
    x_ready <= ($urandom_range(3) != 0);
    w_ready <= ($urandom_range(3) != 0);
  end

  // Compares stream words and counts done pulses
  always @(posedge clk) begin
    if (rst_n) begin
      if (x_flags.done) begin
        x_done_cnt++;
        compare_value("x words at done", x_exp.size(), x_idx);
      end
      if (w_flags.done) begin
        w_done_cnt++;
        compare_value("w words at done", w_exp.size(), w_idx);
      end
      if (z_flags.done) begin
        z_done_cnt++;
      end
      if (x_stream.valid && x_ready) begin
        score_word("x", x_idx, x_exp.size(),
                   (x_idx < x_exp.size()) ? x_exp[x_idx] : '0, x_stream.data);
        x_idx++;
      end
      if (w_stream.valid && w_ready) begin
        score_word("w", w_idx, w_exp.size(),
                   (w_idx < w_exp.size()) ? w_exp[w_idx] : '0, w_stream.data);
        w_idx++;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: a channel never finished within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic launch(input logic sx, input logic sw, input logic sz,
                        input chan_cfg_t cx, input chan_cfg_t cw, input chan_cfg_t cz);
    @(posedge clk);
    x_cfg   <= cx;
    w_cfg   <= cw;
    z_cfg   <= cz;
    x_start <= sx;
    w_start <= sw;
    z_start <= sz;
    @(posedge clk);
    x_start <= 1'b0;
    w_start <= 1'b0;
    z_start <= 1'b0;
  endtask

  // Resets the checker state of one load channel while it is idle
  task automatic expect_load(input logic is_x, input chan_cfg_t cfg);
    if (is_x) begin
      x_exp.delete();
      x_idx      = 0;
      x_done_cnt = 0;
      for (int k = 0; k < cfg.count; k++) begin
        x_exp.push_back(expected_word(cfg.base, cfg.stride, k));
      end
    end else begin
      w_exp.delete();
      w_idx      = 0;
      w_done_cnt = 0;
      for (int k = 0; k < cfg.count; k++) begin
        w_exp.push_back(expected_word(cfg.base, cfg.stride, k));
      end
    end
  endtask

  task automatic wait_done(input logic wx, input logic ww, input logic wz);
    logic seen_x;
    logic seen_w;
    logic seen_z;
    seen_x = !wx;
    seen_w = !ww;
    seen_z = !wz;
    while (!(seen_x && seen_w && seen_z)) begin
      @(posedge clk);
      if (x_flags.done) begin
        seen_x = 1'b1;
      end
      if (w_flags.done) begin
        seen_w = 1'b1;
      end
      if (z_flags.done) begin
        seen_z = 1'b1;
      end
    end
  endtask

  // Word count and a single done pulse a few cycles after the end
  task automatic finish_load(input logic chk_x, input logic chk_w);
    repeat (8) @(posedge clk);
    if (chk_x) begin
      compare_value("x word count", x_exp.size(), x_idx);
      compare_value("x done pulses", 1, x_done_cnt);
    end
    if (chk_w) begin
      compare_value("w word count", w_exp.size(), w_idx);
      compare_value("w done pulses", 1, w_done_cnt);
    end
  endtask

  // Drives z_words with random gaps, holding each word until accepted
  task automatic send_z(input int n);
    int   sent;
    logic hs;
    sent = 0;
    while (sent < n) begin
      @(posedge clk);
      hs = z_stream.valid && z_ready;
      if (hs) begin
        sent++;
      end
      if (sent == n) begin
        z_stream.valid <= 1'b0;
      end else if (hs || !z_stream.valid) begin
        z_stream.valid <= ($urandom_range(3) != 0);
        z_stream.data  <= z_words[sent];
      end
    end
  endtask

  task automatic confirm_idle();
    compare_value("x flags", 0, x_flags);
    compare_value("w flags", 0, w_flags);
    compare_value("z flags", 0, z_flags);
    compare_value("x valid", 0, x_stream.valid);
    compare_value("w valid", 0, w_stream.valid);
    compare_value("mem req", 0, mem_req.req);
    compare_value("z ready", 0, z_ready);
  endtask

  initial begin : run
    chan_cfg_t cx;
    chan_cfg_t cw;
    chan_cfg_t cz;
    int        seen;
    void'($urandom(SEED));
    rst_n    = 1'b0;
    clear    = 1'b0;
    x_start  = 1'b0;
    w_start  = 1'b0;
    z_start  = 1'b0;
    x_cfg    = '0;
    w_cfg    = '0;
    z_cfg    = '0;
    z_stream = '0;
    x_ready  = 1'b0;
    w_ready  = 1'b0;
    mem_rsp  = '0;
    checks   = 0;
    errors   = 0;
    cycles   = 0;
    x_idx    = 0;
    w_idx    = 0;
    x_done_cnt = 0;
    w_done_cnt = 0;
    z_done_cnt = 0;
    cz = '0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a]     = init_word(a);
      exp_mem[a] = init_word(a);
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    test_name = "reset";
    repeat (8) begin
      @(posedge clk);
      confirm_idle();
    end

    // x and w run together with different patterns
    test_name = "x_w_load";
    cx = make_cfg(16, 1, 16);
    cw = make_cfg(200, 5, 12);
    expect_load(1'b1, cx);
    expect_load(1'b0, cw);
    launch(1'b1, 1'b1, 1'b0, cx, cw, cz);
    wait_done(1'b1, 1'b1, 1'b0);
    finish_load(1'b1, 1'b1);

    test_name = "z_store";
    cz = make_cfg(600, 3, 12);
    z_words.delete();
    z_done_cnt = 0;
    for (int k = 0; k < 12; k++) begin
      z_words.push_back($urandom);
      exp_mem[600 + 3 * k] = z_words[k];
    end
    launch(1'b0, 1'b0, 1'b1, cx, cw, cz);
    send_z(12);
    wait_done(1'b0, 1'b0, 1'b1);
    repeat (8) @(posedge clk);
    compare_value("z done pulses", 1, z_done_cnt);
    // Whole memory so that stray writes show up too
    for (int a = 0; a < MEM_WORDS; a++) begin
      compare_value($sformatf("memory word %0d", a), exp_mem[a], mem[a]);
    end

    test_name = "z_readback";
    x_exp      = z_words;
    x_idx      = 0;
    x_done_cnt = 0;
    launch(1'b1, 1'b0, 1'b0, cz, cw, cz);
    wait_done(1'b1, 1'b0, 1'b0);
    finish_load(1'b1, 1'b0);

    test_name = "clear";
    cx = make_cfg(40, 2, 24);
    cw = make_cfg(300, 7, 20);
    expect_load(1'b1, cx);
    expect_load(1'b0, cw);
    z_done_cnt = 0;
    // z gets no words here, so it is still busy when the clear comes
    launch(1'b1, 1'b1, 1'b1, cx, cw, cz);
    seen = 0;
    while (seen < 3) begin
      @(posedge clk);
      if (x_stream.valid && x_ready) begin
        seen++;
      end
    end
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    @(posedge clk);
    compare_value("x busy", 0, x_flags.busy);
    compare_value("w busy", 0, w_flags.busy);
    compare_value("z busy", 0, z_flags.busy);
    repeat (6) begin
      @(posedge clk);
      confirm_idle();
    end
    compare_value("x done pulses", 0, x_done_cnt);
    compare_value("w done pulses", 0, w_done_cnt);
    compare_value("z done pulses", 0, z_done_cnt);

    test_name = "restart";
    cx = make_cfg(100, 4, 10);
    expect_load(1'b1, cx);
    launch(1'b1, 1'b0, 1'b0, cx, cw, cz);
    wait_done(1'b1, 1'b0, 1'b0);
    finish_load(1'b1, 1'b0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: test/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running clock with a period of 4 time units, starting low.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_clock_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

endmodule

// File: hdl/streamer_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two strided load channels (x, w) and one store channel (z) on one port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "streamer_settings.svh"

module streamer_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      clear_i,
  input  logic                      x_start_i,
  input  logic                      w_start_i,
  input  logic                      z_start_i,
  input  streamer_pkg::chan_cfg_t   x_cfg_i,
  input  streamer_pkg::chan_cfg_t   w_cfg_i,
  input  streamer_pkg::chan_cfg_t   z_cfg_i,
  output streamer_pkg::stream_t     x_stream_o,
  output streamer_pkg::stream_t     w_stream_o,
  input  logic                      x_ready_i,
  input  logic                      w_ready_i,
  input  streamer_pkg::stream_t     z_stream_i,
  output logic                      z_ready_o,
  output streamer_pkg::mem_req_t    mem_req_o,
  input  streamer_pkg::mem_rsp_t    mem_rsp_i,
  output streamer_pkg::chan_flags_t x_flags_o,
  output streamer_pkg::chan_flags_t w_flags_o,
  output streamer_pkg::chan_flags_t z_flags_o
);

  import streamer_pkg::*;

  // Arbiter slot of each load channel
  localparam int unsigned X_ID = 0;
  localparam int unsigned W_ID = 1;

  mem_req_t [`STREAMER_N_LOADS-1:0] load_req;
  mem_rsp_t [`STREAMER_N_LOADS-1:0] load_rsp;
  mem_req_t                         store_req;
  mem_rsp_t                         store_rsp;

  load_source i_x_source (
    .clk_i, .rst_n_i, .clear_i,
    .start_i        ( x_start_i      ),
    .cfg_i          ( x_cfg_i        ),
    .mem_req_o      ( load_req[X_ID] ),
    .mem_rsp_i      ( load_rsp[X_ID] ),
    .stream_o       ( x_stream_o     ),
    .stream_ready_i ( x_ready_i      ),
    .flags_o        ( x_flags_o      )
  );

  load_source i_w_source (
    .clk_i, .rst_n_i, .clear_i,
    .start_i        ( w_start_i      ),
    .cfg_i          ( w_cfg_i        ),
    .mem_req_o      ( load_req[W_ID] ),
    .mem_rsp_i      ( load_rsp[W_ID] ),
    .stream_o       ( w_stream_o     ),
    .stream_ready_i ( w_ready_i      ),
    .flags_o        ( w_flags_o      )
  );

  store_sink i_z_sink (
    .clk_i, .rst_n_i, .clear_i,
    .start_i        ( z_start_i  ),
    .cfg_i          ( z_cfg_i    ),
    .stream_i       ( z_stream_i ),
    .stream_ready_o ( z_ready_o  ),
    .mem_req_o      ( store_req  ),
    .mem_rsp_i      ( store_rsp  ),
    .flags_o        ( z_flags_o  )
  );

  mem_arbiter i_arbiter (
    .clk_i, .rst_n_i, .clear_i,
    .load_req_i  ( load_req  ),
    .load_rsp_o  ( load_rsp  ),
    .store_req_i ( store_req ),
    .store_rsp_o ( store_rsp ),
    .mem_req_o   ( mem_req_o ),
    .mem_rsp_i   ( mem_rsp_i )
  );

endmodule

// File: hdl/mem_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// The store channel has fixed priority and can starve the loads.
// Only load reads are tracked, the store side never receives rvalid.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "streamer_settings.svh"

module mem_arbiter (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                                          clear_i,
  input  streamer_pkg::mem_req_t [`STREAMER_N_LOADS-1:0] load_req_i,
  output streamer_pkg::mem_rsp_t [`STREAMER_N_LOADS-1:0] load_rsp_o,
  input  streamer_pkg::mem_req_t                        store_req_i,
  output streamer_pkg::mem_rsp_t                        store_rsp_o,
  output streamer_pkg::mem_req_t                        mem_req_o,
  input  streamer_pkg::mem_rsp_t                        mem_rsp_i
);

  localparam int unsigned N_LOADS = `STREAMER_N_LOADS;
  localparam int unsigned IDX_W   = (N_LOADS > 1) ? $clog2(N_LOADS) : 1;

  logic [IDX_W-1:0] rr_q;
  logic [IDX_W-1:0] sel_idx;
  logic [IDX_W-1:0] rd_idx_q;
  logic             load_sel;
  logic             load_gnt;
  logic             rd_pend_q;

  // Round-robin search, starting at the pointer
  always_comb begin
    int unsigned idx;
    load_sel = 1'b0;
    sel_idx  = rr_q;
    for (int unsigned i = 0; i < N_LOADS; i++) begin
      idx = (rr_q + i) % N_LOADS;
      if (!load_sel && load_req_i[idx].req) begin
        load_sel = 1'b1;
        sel_idx  = IDX_W'(idx);
      end
    end
  end

  always_comb begin
    if (store_req_i.req) begin
      mem_req_o = store_req_i;
    end else if (load_sel) begin
      mem_req_o = load_req_i[sel_idx];
    end else begin
      mem_req_o = '0;
    end
  end

  assign load_gnt = !store_req_i.req && load_sel && mem_rsp_i.gnt;

  // Grant to the selected load, rvalid to the load that read last cycle
  always_comb begin
    for (int unsigned i = 0; i < N_LOADS; i++) begin
      load_rsp_o[i].gnt    = load_gnt && (sel_idx == IDX_W'(i));
      load_rsp_o[i].rvalid = rd_pend_q && mem_rsp_i.rvalid && (rd_idx_q == IDX_W'(i));
      load_rsp_o[i].rdata  = mem_rsp_i.rdata;
    end
  end

  assign store_rsp_o.gnt    = store_req_i.req && mem_rsp_i.gnt;
  assign store_rsp_o.rvalid = 1'b0;
  assign store_rsp_o.rdata  = mem_rsp_i.rdata;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      rr_q      <= '0;
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= load_gnt && !mem_req_o.we;
      if (load_gnt) begin
        rr_q <= (sel_idx == IDX_W'(N_LOADS - 1)) ? '0 : sel_idx + IDX_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rd_idx_q <= sel_idx;
  end

endmodule

// File: hdl/store_sink.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Takes exactly count words per start and writes them in arrival order.
// The count must be at least 1.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "streamer_settings.svh"

module store_sink (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      clear_i,
  input  logic                      start_i,
  input  streamer_pkg::chan_cfg_t   cfg_i,
  input  streamer_pkg::stream_t     stream_i,
  output logic                      stream_ready_o,
  output streamer_pkg::mem_req_t    mem_req_o,
  input  streamer_pkg::mem_rsp_t    mem_rsp_i,
  output streamer_pkg::chan_flags_t flags_o
);

  localparam int unsigned CNT_W = `STREAMER_CNT_W;

  logic                        busy_q;
  logic                        done_q;
  logic [CNT_W-1:0]            accept_left_q;
  logic [`STREAMER_ADDR_W-1:0] addr;
  logic                        last_addr;
  logic                        launch;
  logic                        push;
  logic                        wr_acc;
  logic                        fifo_empty;
  logic                        fifo_full;
  logic [`STREAMER_DATA_W-1:0] fifo_data;

  assign launch         = start_i && !busy_q;
  assign stream_ready_o = busy_q && !fifo_full && (accept_left_q != '0);
  assign push           = stream_i.valid && stream_ready_o;
  assign wr_acc         = mem_req_o.req && mem_rsp_i.gnt;

  // FIFO head is written to the next address of the pattern
  assign mem_req_o.req   = !fifo_empty;
  assign mem_req_o.we    = 1'b1;
  assign mem_req_o.addr  = addr;
  assign mem_req_o.wdata = fifo_data;

  stream_addr_gen i_addr_gen (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .clear_i   ( clear_i   ),
    .load_i    ( launch    ),
    .cfg_i     ( cfg_i     ),
    .advance_i ( wr_acc    ),
    .addr_o    ( addr      ),
    .last_o    ( last_addr )
  );

  stream_fifo #(
    .DEPTH ( `STREAMER_STORE_FIFO_DEPTH )
  ) i_fifo (
    .clk_i   ( clk_i         ),
    .rst_n_i ( rst_n_i       ),
    .clear_i ( clear_i       ),
    .push_i  ( push          ),
    .data_i  ( stream_i.data ),
    .pop_i   ( wr_acc        ),
    .data_o  ( fifo_data     ),
    .empty_o ( fifo_empty    ),
    .full_o  ( fifo_full     )
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      busy_q        <= 1'b0;
      done_q        <= 1'b0;
      accept_left_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (launch) begin
        busy_q        <= 1'b1;
        accept_left_q <= cfg_i.count;
      end else begin
        if (push) begin
          accept_left_q <= accept_left_q - CNT_W'(1);
        end
        // Finished once the final write is granted
        if (wr_acc && last_addr) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  assign flags_o.busy = busy_q;
  assign flags_o.done = done_q;

endmodule

// File: hdl/load_source.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reads are limited by FIFO credit, so a response always finds room.
// The count must be at least 1; start is ignored while busy.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "streamer_settings.svh"

module load_source (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      clear_i,
  input  logic                      start_i,
  input  streamer_pkg::chan_cfg_t   cfg_i,
  output streamer_pkg::mem_req_t    mem_req_o,
  input  streamer_pkg::mem_rsp_t    mem_rsp_i,
  output streamer_pkg::stream_t     stream_o,
  input  logic                      stream_ready_i,
  output streamer_pkg::chan_flags_t flags_o
);

  localparam int unsigned DEPTH = `STREAMER_LOAD_FIFO_DEPTH;
  localparam int unsigned CRD_W = $clog2(DEPTH + 1);
  localparam int unsigned CNT_W = `STREAMER_CNT_W;

  logic                        busy_q;
  logic                        done_q;
  logic                        req_open_q;
  logic [CRD_W-1:0]            credit_q;
  logic [CNT_W-1:0]            deliver_left_q;
  logic [`STREAMER_ADDR_W-1:0] addr;
  logic                        last_addr;
  logic                        launch;
  logic                        req_acc;
  logic                        pop;
  logic                        fifo_empty;
  logic [`STREAMER_DATA_W-1:0] fifo_data;

  assign launch  = start_i && !busy_q;
  assign req_acc = mem_req_o.req && mem_rsp_i.gnt;
  assign pop     = stream_o.valid && stream_ready_i;

  // Credit covers reads in flight plus words held in the FIFO
  assign mem_req_o.req   = req_open_q && (credit_q < CRD_W'(DEPTH));
  assign mem_req_o.we    = 1'b0;
  assign mem_req_o.addr  = addr;
  assign mem_req_o.wdata = '0;

  stream_addr_gen i_addr_gen (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .clear_i   ( clear_i   ),
    .load_i    ( launch    ),
    .cfg_i     ( cfg_i     ),
    .advance_i ( req_acc   ),
    .addr_o    ( addr      ),
    .last_o    ( last_addr )
  );

  stream_fifo #(
    .DEPTH ( DEPTH )
  ) i_fifo (
    .clk_i   ( clk_i            ),
    .rst_n_i ( rst_n_i          ),
    .clear_i ( clear_i          ),
    .push_i  ( mem_rsp_i.rvalid ),
    .data_i  ( mem_rsp_i.rdata  ),
    .pop_i   ( pop              ),
    .data_o  ( fifo_data        ),
    .empty_o ( fifo_empty       ),
    .full_o  (                  )
  );

  assign stream_o.valid = !fifo_empty;
  assign stream_o.data  = fifo_data;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      busy_q         <= 1'b0;
      done_q         <= 1'b0;
      req_open_q     <= 1'b0;
      credit_q       <= '0;
      deliver_left_q <= '0;
    end else begin
      done_q   <= 1'b0;
      credit_q <= credit_q + CRD_W'(req_acc) - CRD_W'(pop);
      if (launch) begin
        busy_q         <= 1'b1;
        req_open_q     <= 1'b1;
        deliver_left_q <= cfg_i.count;
      end else begin
        // Last address handed out, no more requests
        if (req_acc && last_addr) begin
          req_open_q <= 1'b0;
        end
        if (pop) begin
          deliver_left_q <= deliver_left_q - CNT_W'(1);
          if (deliver_left_q == CNT_W'(1)) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  assign flags_o.busy = busy_q;
  assign flags_o.done = done_q;

endmodule

// File: hdl/stream_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// A push into a full FIFO is dropped unless a pop happens in the same cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "streamer_settings.svh"

module stream_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        clear_i,
  input  logic                        push_i,
  input  logic [`STREAMER_DATA_W-1:0] data_i,
  input  logic                        pop_i,
  output logic [`STREAMER_DATA_W-1:0] data_o,
  output logic                        empty_o,
  output logic                        full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [`STREAMER_DATA_W-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]            wr_ptr_q;
  logic [PTR_W-1:0]            rd_ptr_q;
  logic [CNT_W-1:0]            cnt_q;
  logic [CNT_W-1:0]            cnt_d;
  logic                        full_q;
  logic                        empty_q;
  logic                        do_push;
  logic                        do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  assign do_pop  = pop_i && !empty_q;
  assign do_push = push_i && (!full_q || do_pop);

  always_comb begin
    cnt_d = cnt_q;
    if (do_push && !do_pop) begin
      cnt_d = cnt_q + CNT_W'(1);
    end else if (do_pop && !do_push) begin
      cnt_d = cnt_q - CNT_W'(1);
    end
  end

  // Pointers, occupancy and the registered status flags
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      cnt_q   <= cnt_d;
      full_q  <= (cnt_d == CNT_W'(DEPTH));
      empty_q <= (cnt_d == '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = empty_q;
  assign full_o  = full_q;

endmodule

// File: hdl/stream_addr_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// The count must be at least 1. Addresses wrap at the address width.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "streamer_settings.svh"

module stream_addr_gen (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        clear_i,
  input  logic                        load_i,
  input  streamer_pkg::chan_cfg_t     cfg_i,
  input  logic                        advance_i,
  output logic [`STREAMER_ADDR_W-1:0] addr_o,
  output logic                        last_o
);

  localparam int unsigned CNT_W = `STREAMER_CNT_W;

  logic [`STREAMER_ADDR_W-1:0] addr_q;
  logic [`STREAMER_ADDR_W-1:0] stride_q;
  logic [CNT_W-1:0]            left_q;

  // Remaining addresses including the current one
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      left_q <= '0;
    end else if (load_i) begin
      left_q <= cfg_i.count;
    end else if (advance_i && left_q != '0) begin
      left_q <= left_q - CNT_W'(1);
    end
  end

  // Current address and step size
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      addr_q   <= cfg_i.base;
      stride_q <= cfg_i.stride;
    end else if (advance_i) begin
      addr_q <= addr_q + stride_q;
    end
  end

  assign addr_o = addr_q;
  assign last_o = (left_q == CNT_W'(1));

endmodule

// File: hdl/streamer_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bundled types for the memory port, the streams and channel control.
// The ready half of a stream is not part of stream_t.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "streamer_settings.svh"

package streamer_pkg;

  // Request towards memory, held stable until req and gnt meet
  typedef struct packed {
    logic                        req;
    logic                        we;
    logic [`STREAMER_ADDR_W-1:0] addr;
    logic [`STREAMER_DATA_W-1:0] wdata;
  } mem_req_t;

  // Response from memory, rvalid one cycle after an accepted read
  typedef struct packed {
    logic                        gnt;
    logic                        rvalid;
    logic [`STREAMER_DATA_W-1:0] rdata;
  } mem_rsp_t;

  // Forward half of a valid/ready stream
  typedef struct packed {
    logic                        valid;
    logic [`STREAMER_DATA_W-1:0] data;
  } stream_t;

  // Strided access pattern of one channel
  typedef struct packed {
    logic [`STREAMER_ADDR_W-1:0] base;
    logic [`STREAMER_ADDR_W-1:0] stride;
    logic [`STREAMER_CNT_W-1:0]  count;
  } chan_cfg_t;

  typedef struct packed {
    logic busy;
    logic done;
  } chan_flags_t;

endpackage

// File: hdl/streamer_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Global sizes of the memory streamer. Addresses count words, not bytes.
// The struct types in streamer_pkg take their field widths from here.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef STREAMER_SETTINGS_SVH
`define STREAMER_SETTINGS_SVH

// Word and address widths of the shared memory port
`define STREAMER_DATA_W 32
`define STREAMER_ADDR_W 16

// Width of the per-channel word count
`define STREAMER_CNT_W 16

// Buffer depths, load side sized for a slow consumer
`define STREAMER_LOAD_FIFO_DEPTH 4
`define STREAMER_STORE_FIFO_DEPTH 2

// Number of load channels behind the arbiter (x and w)
`define STREAMER_N_LOADS 2

`endif
